//--- flist.f
rtl/uart_pkg.sv
rtl/uart_tx.sv
rtl/uart_rx.sv
rtl/uart_top.sv
verification/uart_clk_gen.sv
verification/uart_assert.sv
verification/uart_tb.sv

//--- run_sim.sh
#!/bin/bash
# Build the UART testbench with Verilator, run it and scan the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --assert --timescale 1ns/1ps --top-module uart_tb -f flist.f \
    && ./obj_dir/Vuart_tb > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "Build or simulation run failed"; exit 1; }

cat sim.log
grep -qF '*** FAILED ***' sim.log && { echo "Simulation reported failure"; exit 1; } \
    || echo "Simulation reported success"

//--- verification/uart_tb.sv
// UART testbench
// Runs a table of frames through the DUT, either looped back from its own
// transmitter or hand-built on the serial line with parity, stop-bit and
// start-glitch faults, and checks the received byte and error flags
`default_nettype none

module uart_tb
    import uart_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_FREQ     = 1_000_000;
    localparam int BAUD_RATE    = 100_000;
    localparam int PARITY_ODD   = 0;
    localparam int CLKS_PER_BIT = CLK_FREQ / BAUD_RATE;
    localparam int TIMEOUT      = 15 * CLKS_PER_BIT;  // 15 bit periods
    localparam bit ODD_PAR      = (PARITY_ODD != 0);

    typedef struct packed
    {
        uart_data_t data;
        logic       hand;       // Hand-built frame, else loopback
        logic       flip_par;
        logic       stop_bit;
        logic       glitch;     // Short low pulse instead of a frame
        logic [2:0] exp_flags;  // rx_done, parity_error, framing_error
    } row_t;

    logic       clk;
    logic       reset;
    uart_data_t tx_data;
    uart_data_t rx_data;
    logic       tx_start;
    logic       tx;
    logic       tx_busy;
    logic       rx;
    logic       rx_done;
    logic       parity_error;
    logic       framing_error;
    logic       use_loop;       // DUT rx taken from its own tx
    logic       line;           // Serial line driven by the testbench
    row_t       rows[$];
    string      names[$];
    uart_data_t got_data;
    logic [2:0] got_flags;
    int         done_count;
    int         errors = 0;
    int         checks = 0;
    integer     seed = 41;

    uart_clk_gen i_clk_gen (.*);

    uart_top #(
        .CLK_FREQ   (CLK_FREQ),
        .BAUD_RATE  (BAUD_RATE),
        .PARITY_ODD (PARITY_ODD)
    ) i_dut (.*);

    assign rx = use_loop ? tx : line;

    // Record each receive strobe with its results
    always @(posedge clk)
    begin
        if (reset)
        begin
            done_count <= 0;
        end
        else if (rx_done)
        begin
            done_count <= done_count + 1;
            got_data   <= rx_data;
            got_flags  <= {rx_done, parity_error, framing_error};
        end
    end

    task automatic check(input string what, input logic [7:0] expected,
                         input logic [7:0] actual);
        checks++;
        if (expected !== actual)
        begin
            errors++;
            $display("ERROR %s: expected %0h, actual %0h", what, expected, actual);
        end
    endtask

    task automatic add_row(input string name, input row_t row);
        names.push_back(name);
        rows.push_back(row);
    endtask

    task automatic drive_bit(input logic value);
        line <= value;
        repeat (CLKS_PER_BIT) @(posedge clk);
    endtask

    // Start, eight data bits LSB first, parity, stop, then back to idle
    task automatic send_frame(input row_t row);
        drive_bit(1'b0);
        for (int i = 0; i < 8; i++)
        begin
            drive_bit(row.data[i]);
        end
        drive_bit((^row.data) ^ ODD_PAR ^ row.flip_par);
        drive_bit(row.stop_bit);
        if (!row.stop_bit)
        begin
            drive_bit(1'b0);  // Low line held past the stop sample
        end
        line <= 1'b1;
    endtask

    task automatic wait_not_busy(input string name);
        int waited;
        waited = 0;
        while (tx_busy && waited < TIMEOUT)
        begin
            @(posedge clk);
            waited++;
        end
        if (tx_busy)
        begin
            errors++;
            $display("%s: transmitter still busy after the timeout", name);
        end
    endtask

    task automatic run_row(input string name, input row_t row);
        int start_cnt;
        int waited;
        start_cnt = done_count;
        use_loop  <= ~row.hand;
        if (!row.hand)
        begin
            tx_data  <= row.data;
            tx_start <= 1'b1;
            @(posedge clk);
            tx_start <= 1'b0;
        end
        else if (row.glitch)
        begin
            line <= 1'b0;
            repeat (CLKS_PER_BIT / 2 - 2) @(posedge clk);  // Under half a bit
            line <= 1'b1;
        end
        else
        begin
            send_frame(row);
        end
        waited = 0;
        while (done_count == start_cnt && waited < TIMEOUT)
        begin
            @(posedge clk);
            waited++;
        end
        if (done_count != start_cnt)
        begin
            check({name, " flags"}, {5'd0, row.exp_flags}, {5'd0, got_flags});
            if (row.exp_flags[2])
            begin
                check({name, " rx_data"}, row.data, got_data);
            end
        end
        else if (row.exp_flags[2])
        begin
            errors++;
            $display("%s: frame never completed, no rx_done within the timeout", name);
        end
        else
        begin
            $display("%s: no rx_done, as expected", name);
        end
        wait_not_busy(name);
        repeat (2 * CLKS_PER_BIT) @(posedge clk);  // Idle line between rows
    endtask

    initial
    begin
        int waited;
        int start_cnt;
        tx_data  = '0;
        tx_start = 1'b0;
        line     = 1'b1;
        use_loop = 1'b1;

        //       name              data   hand  flip  stop  glitch done/perr/ferr
        add_row("loop_00",   row_t'{8'h00, 1'b0, 1'b0, 1'b1, 1'b0, 3'b100});
        add_row("loop_ff",   row_t'{8'hFF, 1'b0, 1'b0, 1'b1, 1'b0, 3'b100});
        add_row("loop_a5",   row_t'{8'hA5, 1'b0, 1'b0, 1'b1, 1'b0, 3'b100});
        add_row("loop_c1",   row_t'{8'hC1, 1'b0, 1'b0, 1'b1, 1'b0, 3'b100});
        add_row("parity_err", row_t'{8'h5A, 1'b1, 1'b1, 1'b1, 1'b0, 3'b110});
        add_row("framing_err", row_t'{8'hC3, 1'b1, 1'b0, 1'b0, 1'b0, 3'b101});
        add_row("after_framing", row_t'{8'h97, 1'b1, 1'b0, 1'b1, 1'b0, 3'b100});
        add_row("start_glitch", row_t'{8'h00, 1'b1, 1'b0, 1'b1, 1'b1, 3'b000});
        for (int i = 0; i < 4; i++)
        begin
            add_row("loop_random",
                    row_t'{8'($random(seed)), 1'b0, 1'b0, 1'b1, 1'b0, 3'b100});
        end

        @(posedge clk);
        waited = 0;
        while (reset !== 1'b0 && waited < 20)
        begin
            @(posedge clk);
            waited++;
        end
        if (reset !== 1'b0)
        begin
            errors++;
            $display("Reset was never released");
        end
        @(posedge clk);
        // tx high, everything else low
        check("reset outputs", 8'b0001_0000,
              {3'b000, tx, tx_busy, rx_done, parity_error, framing_error});
        check("reset rx_data", 8'h00, rx_data);

        for (int i = 0; i < rows.size(); i++)
        begin
            run_row(names[i], rows[i]);
        end

        // Second strobe lands mid-frame and has to be dropped
        start_cnt = done_count;
        use_loop  <= 1'b1;
        tx_data   <= 8'h3C;
        tx_start  <= 1'b1;
        @(posedge clk);
        tx_start  <= 1'b0;
        repeat (3 * CLKS_PER_BIT) @(posedge clk);
        check("busy_strobe tx_busy high", 8'h01, {7'd0, tx_busy});
        tx_data  <= 8'hC3;
        tx_start <= 1'b1;
        @(posedge clk);
        tx_start <= 1'b0;
        wait_not_busy("busy_strobe");
        check("busy_strobe frames", 8'h01, 8'(done_count - start_cnt));
        check("busy_strobe rx_data", 8'h3C, got_data);
        check("busy_strobe tx_busy low", 8'h00, {7'd0, tx_busy});
        run_row("busy_third", row_t'{8'h69, 1'b0, 1'b0, 1'b1, 1'b0, 3'b100});

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
        begin
            $display("*** PASSED ***");
        end
        else
        begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verification/uart_assert.sv
// Transmitter assertions
// Bound into uart_tx. Checks the idle line level, the busy flag against
// the FSM state and that a strobe during a frame leaves the latched byte
`default_nettype none

module uart_assert
    import uart_pkg::*;
(
    input wire        clk,
    input wire        reset,
    input tx_state_t  state,
    input wire        tx,
    input wire        tx_busy,
    input wire        tx_start,
    input uart_data_t data_reg
);

    timeunit 1ns;
    timeprecision 1ps;

    idle_line_high: assert property (@(posedge clk) disable iff (reset)
        (state == TX_IDLE) |-> tx)
        else $error("tx is low while the transmitter is idle");

    busy_matches_state: assert property (@(posedge clk) disable iff (reset)
        tx_busy == (state != TX_IDLE))
        else $error("tx_busy does not match the transmitter state");

    // The byte may only change on an accepted strobe
    dropped_strobe: assert property (@(posedge clk) disable iff (reset)
        (tx_start && tx_busy) |=> $stable(data_reg))
        else $error("A strobe during a frame changed the latched byte");

endmodule

bind uart_tx uart_assert i_assert
(
    .clk      (clk),
    .reset    (reset),
    .state    (state),
    .tx       (tx),
    .tx_busy  (tx_busy),
    .tx_start (tx_start),
    .data_reg (data_reg)
);

`default_nettype wire

//--- verification/uart_clk_gen.sv
// Testbench clock and reset source
// 20 ns clock, reset held high for the first five rising edges
`default_nettype none

module uart_clk_gen
(
    output logic clk,
    output logic reset
);

    timeunit 1ns;
    timeprecision 1ps;

    initial
    begin
        clk = 1'b0;
        forever #10 clk = ~clk;  // 20 ns period
    end

    initial
    begin
        reset = 1'b1;
        repeat (5) @(posedge clk);
        reset <= 1'b0;
    end

endmodule

`default_nettype wire

//--- rtl/uart_top.sv
// UART top level
// One transmitter and one independent receiver sharing clock and reset.
// Baud rate and parity mode are set here for both sides.
`default_nettype none

module uart_top
    import uart_pkg::*;
#(
    parameter int CLK_FREQ   = 50_000_000,
    parameter int BAUD_RATE  = 9600,
    parameter int PARITY_ODD = 0       // 0 even, 1 odd
)
(
    input  wire        clk,
    input  wire        reset,
    // Transmit side
    input  uart_data_t tx_data,
    input  wire        tx_start,
    output logic       tx,
    output logic       tx_busy,
    // Receive side
    input  wire        rx,
    output uart_data_t rx_data,
    output logic       rx_done,
    output logic       parity_error,
    output logic       framing_error
);

    uart_tx #(
        .CLK_FREQ   (CLK_FREQ),
        .BAUD_RATE  (BAUD_RATE),
        .PARITY_ODD (PARITY_ODD)
    ) i_tx (
        .clk      (clk),
        .reset    (reset),
        .tx_data  (tx_data),
        .tx_start (tx_start),
        .tx       (tx),
        .tx_busy  (tx_busy)
    );

    uart_rx #(
        .CLK_FREQ   (CLK_FREQ),
        .BAUD_RATE  (BAUD_RATE),
        .PARITY_ODD (PARITY_ODD)
    ) i_rx (
        .clk           (clk),
        .reset         (reset),
        .rx            (rx),
        .rx_data       (rx_data),
        .rx_done       (rx_done),
        .parity_error  (parity_error),
        .framing_error (framing_error)
    );

endmodule

`default_nettype wire

//--- rtl/uart_rx.sv
// UART receiver
// Synchronizes the serial line, confirms the start bit at mid-bit and
// samples eight data bits, parity and stop once per bit period.
// Reports the byte with a one-cycle rx_done strobe together with the
// parity and framing results.
`default_nettype none

module uart_rx
    import uart_pkg::*;
#(
    parameter int CLK_FREQ   = 50_000_000,
    parameter int BAUD_RATE  = 9600,
    parameter int PARITY_ODD = 0
)
(
    input  wire        clk,
    input  wire        reset,
    input  wire        rx,
    output uart_data_t rx_data,
    output logic       rx_done,
    output logic       parity_error,
    output logic       framing_error
);

    localparam int CLKS_PER_BIT = CLK_FREQ / BAUD_RATE;
    localparam int HALF_BIT     = CLKS_PER_BIT / 2;
    localparam int CNT_W        = $clog2(CLKS_PER_BIT + 1);
    localparam bit ODD          = (PARITY_ODD != 0);

    localparam logic [CNT_W-1:0] LAST_CNT = CNT_W'(CLKS_PER_BIT - 1);
    localparam logic [CNT_W-1:0] HALF_CNT = CNT_W'(HALF_BIT - 1);

    rx_state_t        state;
    logic [CNT_W-1:0] clk_cnt;
    bit_idx_t         bit_idx;
    uart_data_t       shift_reg;
    logic             par_acc;    // Running XOR of data and parity bits
    logic             rx_meta;
    logic             rx_sync;
    logic             rx_last;    // Previous synchronized value, for edge detect
    logic             sample;
    logic             fall_edge;

    // Two-flop synchronizer plus one stage for edge detection
    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
            rx_last <= 1'b1;
        end
        else
        begin
            rx_meta <= rx;
            rx_sync <= rx_meta;
            rx_last <= rx_sync;
        end
    end

    // A start needs the line to have been high first, so a low stop bit
    // cannot retrigger the receiver
    assign fall_edge = rx_last & ~rx_sync;

    // Half a bit in START, a full bit everywhere else
    assign sample = (state == RX_START) ? (clk_cnt == HALF_CNT) : (clk_cnt == LAST_CNT);

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            clk_cnt <= '0;
        end
        else if (state == RX_IDLE || sample)
        begin
            clk_cnt <= '0;
        end
        else
        begin
            clk_cnt <= clk_cnt + 1'b1;
        end
    end

    // LSB arrives first, so shift in from the top
    always_ff @(posedge clk)
    begin
        if (state == RX_DATA && sample)
        begin
            shift_reg <= {rx_sync, shift_reg[7:1]};
        end
    end

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            state         <= RX_IDLE;
            bit_idx       <= '0;
            par_acc       <= 1'b0;
            rx_data       <= '0;
            rx_done       <= 1'b0;
            parity_error  <= 1'b0;
            framing_error <= 1'b0;
        end
        else
        begin
            rx_done       <= 1'b0;  // Strobes by default
            parity_error  <= 1'b0;
            framing_error <= 1'b0;
            unique case (state)
                RX_IDLE:
                begin
                    if (fall_edge)
                    begin
                        state <= RX_START;
                    end
                end
                RX_START:
                begin
                    if (sample)
                    begin
                        // Line back high means a glitch, not a start bit
                        state   <= rx_sync ? RX_IDLE : RX_DATA;
                        bit_idx <= '0;
                        par_acc <= 1'b0;
                    end
                end
                RX_DATA:
                begin
                    if (sample)
                    begin
                        par_acc <= par_acc ^ rx_sync;
                        bit_idx <= bit_idx + 3'd1;
                        if (bit_idx == 3'd7)
                        begin
                            state <= RX_PARITY;
                        end
                    end
                end
                RX_PARITY:
                begin
                    if (sample)
                    begin
                        par_acc <= par_acc ^ rx_sync;
                        state   <= RX_STOP;
                    end
                end
                RX_STOP:
                begin
                    if (sample)
                    begin
                        rx_data       <= shift_reg;
                        rx_done       <= 1'b1;
                        parity_error  <= (par_acc != ODD);
                        framing_error <= ~rx_sync;
                        state         <= RX_IDLE;
                    end
                end
                default:
                begin
                    state <= RX_IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- rtl/uart_tx.sv
// UART transmitter
// Latches a byte on a single-cycle strobe and sends start, eight data
// bits LSB first, parity and stop. Strobes during a frame are dropped.
`default_nettype none

module uart_tx
    import uart_pkg::*;
#(
    parameter int CLK_FREQ   = 50_000_000,
    parameter int BAUD_RATE  = 9600,
    parameter int PARITY_ODD = 0
)
(
    input  wire        clk,
    input  wire        reset,
    input  uart_data_t tx_data,
    input  wire        tx_start,
    output logic       tx,
    output logic       tx_busy
);

    localparam int CLKS_PER_BIT = CLK_FREQ / BAUD_RATE;
    localparam int CNT_W        = $clog2(CLKS_PER_BIT + 1);
    localparam bit ODD          = (PARITY_ODD != 0);

    localparam logic [CNT_W-1:0] LAST_CNT = CNT_W'(CLKS_PER_BIT - 1);

    tx_state_t        state;
    logic [CNT_W-1:0] clk_cnt;
    bit_idx_t         bit_idx;
    bit_idx_t         next_idx;
    uart_data_t       data_reg;    // Byte of the frame in flight
    logic             parity_bit;
    logic             bit_end;
    logic             accept;

    assign accept     = (state == TX_IDLE) && tx_start;
    assign bit_end    = (clk_cnt == LAST_CNT);
    assign next_idx   = bit_idx + 3'd1;
    assign parity_bit = (^data_reg) ^ ODD;

    always_ff @(posedge clk)
    begin
        if (accept)
        begin
            data_reg <= tx_data;
        end
    end

    // Bit period counter, restarts on every bit boundary
    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            clk_cnt <= '0;
        end
        else if (state == TX_IDLE || bit_end)
        begin
            clk_cnt <= '0;
        end
        else
        begin
            clk_cnt <= clk_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            state   <= TX_IDLE;
            bit_idx <= '0;
            tx      <= 1'b1;
            tx_busy <= 1'b0;
        end
        else
        begin
            unique case (state)
                TX_IDLE:
                begin
                    if (tx_start)
                    begin
                        state   <= TX_START;
                        tx      <= 1'b0;  // Start bit
                        tx_busy <= 1'b1;
                    end
                end
                TX_START:
                begin
                    if (bit_end)
                    begin
                        state   <= TX_DATA;
                        bit_idx <= '0;
                        tx      <= data_reg[0];
                    end
                end
                TX_DATA:
                begin
                    if (bit_end)
                    begin
                        if (bit_idx == 3'd7)
                        begin
                            state <= TX_PARITY;
                            tx    <= parity_bit;
                        end
                        else
                        begin
                            bit_idx <= next_idx;
                            tx      <= data_reg[next_idx];
                        end
                    end
                end
                TX_PARITY:
                begin
                    if (bit_end)
                    begin
                        state <= TX_STOP;
                        tx    <= 1'b1;
                    end
                end
                TX_STOP:
                begin
                    if (bit_end)
                    begin
                        state   <= TX_IDLE;
                        tx_busy <= 1'b0;  // Line stays high
                    end
                end
                default:
                begin
                    state   <= TX_IDLE;
                    tx      <= 1'b1;
                    tx_busy <= 1'b0;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- rtl/uart_pkg.sv
// UART shared definitions
// Byte type, bit index type and the state encodings used by the
// transmitter and the receiver
`default_nettype none

package uart_pkg;

    // One byte on the parallel side
    typedef logic [7:0] uart_data_t;

    // Position of a data bit within the frame
    typedef logic [2:0] bit_idx_t;

    // Transmitter FSM
    typedef enum logic [2:0]
    {
        TX_IDLE,   // Line high, waiting for a strobe
        TX_START,  // Driving the start bit
        TX_DATA,   // Eight data bits, LSB first
        TX_PARITY,
        TX_STOP
    } tx_state_t;

    // Receiver FSM
    typedef enum logic [2:0]
    {
        RX_IDLE,   // Waiting for a falling edge
        RX_START,  // Confirming the start bit at mid-bit
        RX_DATA,
        RX_PARITY,
        RX_STOP    // Stop sample, results reported here
    } rx_state_t;

endpackage

`default_nettype wire
